// ==== src/hyper_pkg.sv ====
/*
 * Shared sizes, command and state enums, host request and response
 * structs, pad structs for the HyperBus controller
 */

package hyper_pkg;

    localparam int ADDR_W        = 24;
    localparam int DATA_W        = 16;
    localparam int BYTE_W        = 8;
    localparam int CA_BYTES      = 6;
    localparam int LATENCY_BYTES = 12;
    localparam int DATA_BYTES    = 2;
    localparam int READ_TIMEOUT  = 32;
    localparam int CS_GAP        = 2;
    localparam int TIMER_W       = 6;

    // Derived widths of the outgoing byte stream
    localparam int CA_W = CA_BYTES * BYTE_W;
    localparam int TX_W = (CA_BYTES + DATA_BYTES) * BYTE_W;

    typedef enum logic {
        CMD_READ,
        CMD_WRITE
    } hyper_cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CA,
        ST_LATENCY,
        ST_WDATA,
        ST_RDATA,
        ST_ACK,
        ST_GAP
    } hyper_state_e;

    typedef struct packed {
        hyper_cmd_e          cmd;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
    } host_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]   rdata;
        logic                err;
    } host_rsp_t;

    typedef struct packed {
        logic                cs_n;
        logic                ck;
        logic                reset_n;
        logic [BYTE_W-1:0]   dq;
        logic                dq_oe;
    } hyper_pad_out_t;

    typedef struct packed {
        logic [BYTE_W-1:0]   dq;
        logic                rwds;
    } hyper_pad_in_t;

endpackage

// ==== src/hyper_phase_timer.sv ====
/*
 * Loadable down-counter for bus phase lengths and read timeout
 */

`timescale 1ns/100ps

module hyper_phase_timer (
    input  logic                          sys_clk,
    input  logic                          reset_i,
    input  logic                          load_i,
    input  logic [hyper_pkg::TIMER_W-1:0] count_i,
    output logic                          done_o
);
    import hyper_pkg::*;

    logic [TIMER_W-1:0] cnt_q;

    // Loaded with count-1 so done falls on the last cycle of the phase
    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= count_i - TIMER_W'(1);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - TIMER_W'(1);
        end
    end

    assign done_o = (cnt_q == '0);

endmodule

// ==== src/hyper_tx_shifter.sv ====
/*
 * Command-address and write-data byte shifter, most significant byte
 * first onto DQ
 */

`timescale 1ns/100ps

module hyper_tx_shifter (
    input  logic                         sys_clk,
    input  logic                         reset_i,
    input  logic                         load_i,
    input  hyper_pkg::host_req_t         req_i,
    input  logic                         shift_i,
    output logic [hyper_pkg::BYTE_W-1:0] dq_o
);
    import hyper_pkg::*;

    logic [TX_W-1:0] sr_q;
    logic [CA_W-1:0] ca;

    // Command-address word
    always_comb begin
        ca         = '0;
        ca[47]     = (req_i.cmd == CMD_READ);
        ca[46]     = 1'b0;
        // Linear burst
        ca[45]     = 1'b1;
        ca[44:16]  = {8'h00, req_i.addr[ADDR_W-1:3]};
        ca[2:0]    = req_i.addr[2:0];
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            sr_q <= '0;
        end else if (load_i) begin
            sr_q <= {ca, req_i.wdata};
        end else if (shift_i) begin
            sr_q <= {sr_q[TX_W-BYTE_W-1:0], {BYTE_W{1'b0}}};
        end
    end

    assign dq_o = sr_q[TX_W-1 -: BYTE_W];

endmodule

// ==== src/hyper_rx_capture.sv ====
/*
 * Read data capture: RWDS-qualified bytes assembled high byte first
 */

`timescale 1ns/100ps

module hyper_rx_capture (
    input  logic                         sys_clk,
    input  logic                         reset_i,
    input  logic                         clear_i,
    input  logic                         enable_i,
    input  hyper_pkg::hyper_pad_in_t     pad_i,
    output logic [hyper_pkg::DATA_W-1:0] word_o,
    output logic                         full_o
);
    import hyper_pkg::*;

    localparam int CNT_W = $clog2(DATA_BYTES + 1);

    logic [CNT_W-1:0]  cnt_q;
    logic [DATA_W-1:0] word_q;
    logic              take;

    // Device marks each valid byte with RWDS high
    assign take = enable_i && pad_i.rwds && (cnt_q != CNT_W'(DATA_BYTES));

    always_ff @(posedge sys_clk) begin
        if (reset_i || clear_i) begin
            cnt_q <= '0;
        end else if (take) begin
            cnt_q <= cnt_q + CNT_W'(1);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (take) begin
            word_q <= {word_q[DATA_W-BYTE_W-1:0], pad_i.dq};
        end
    end

    assign word_o = word_q;
    assign full_o = (cnt_q == CNT_W'(DATA_BYTES));

endmodule

// ==== src/hyper_txn_fsm.sv ====
/*
 * Transaction FSM: phase sequencing, timer loads, bus clock,
 * chip select, error flag and the host req/ack handshake
 */

`timescale 1ns/100ps

module hyper_txn_fsm (
    input  logic                          sys_clk,
    input  logic                          reset_i,
    input  logic                          req_i,
    output logic                          ack_o,
    input  hyper_pkg::hyper_cmd_e         cmd_i,
    input  logic                          timer_done_i,
    output logic                          timer_load_o,
    output logic [hyper_pkg::TIMER_W-1:0] timer_count_o,
    output logic                          tx_load_o,
    output logic                          tx_shift_o,
    output logic                          rx_clear_o,
    output logic                          rx_enable_o,
    input  logic                          rx_full_i,
    output logic                          err_o,
    output logic                          cs_n_o,
    output logic                          ck_o,
    output logic                          dq_oe_o,
    output logic                          reset_n_o
);
    import hyper_pkg::*;

    hyper_state_e state_q;
    hyper_state_e state_d;
    logic         accept;
    logic         ack_q;
    logic         err_q;
    logic         ck_q;
    logic         reset_n_q;

    // States in which chip select is held low
    function automatic logic bus_active(input hyper_state_e st);
        return (st == ST_CA) || (st == ST_LATENCY) || (st == ST_WDATA) || (st == ST_RDATA);
    endfunction

    assign accept = (state_q == ST_IDLE) && req_i && !ack_q;

    always_comb begin
        state_d       = state_q;
        timer_load_o  = 1'b0;
        timer_count_o = '0;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d       = ST_CA;
                    timer_load_o  = 1'b1;
                    timer_count_o = TIMER_W'(CA_BYTES);
                end
            end
            ST_CA: begin
                if (timer_done_i) begin
                    state_d       = ST_LATENCY;
                    timer_load_o  = 1'b1;
                    timer_count_o = TIMER_W'(LATENCY_BYTES);
                end
            end
            ST_LATENCY: begin
                if (timer_done_i) begin
                    timer_load_o = 1'b1;
                    if (cmd_i == CMD_WRITE) begin
                        state_d       = ST_WDATA;
                        timer_count_o = TIMER_W'(DATA_BYTES);
                    end else begin
                        // Same timer doubles as the read-data watchdog
                        state_d       = ST_RDATA;
                        timer_count_o = TIMER_W'(READ_TIMEOUT);
                    end
                end
            end
            ST_WDATA: begin
                if (timer_done_i) begin
                    state_d = ST_ACK;
                end
            end
            ST_RDATA: begin
                if (rx_full_i || timer_done_i) begin
                    state_d = ST_ACK;
                end
            end
            ST_ACK: begin
                // Host released req, start the chip select gap
                if (!req_i) begin
                    state_d       = ST_GAP;
                    timer_load_o  = 1'b1;
                    timer_count_o = TIMER_W'(CS_GAP);
                end
            end
            ST_GAP: begin
                if (timer_done_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            state_q   <= ST_IDLE;
            ack_q     <= 1'b0;
            err_q     <= 1'b0;
            ck_q      <= 1'b0;
            reset_n_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            ack_q     <= (state_q == ST_ACK) && req_i;
            reset_n_q <= 1'b1;
            // Look at next state so ck is already 0 when cs_n rises
            ck_q      <= bus_active(state_d) ? ~ck_q : 1'b0;
            if (accept) begin
                err_q <= 1'b0;
            end else if ((state_q == ST_RDATA) && timer_done_i && !rx_full_i) begin
                err_q <= 1'b1;
            end
        end
    end

    // Byte 6 moves up at the end of CA, byte 7 on the first data cycle
    assign tx_load_o   = accept;
    assign tx_shift_o  = (state_q == ST_CA) || ((state_q == ST_WDATA) && !timer_done_i);
    assign rx_clear_o  = accept;
    assign rx_enable_o = (state_q == ST_RDATA);

    assign ack_o     = ack_q;
    assign err_o     = err_q;
    assign cs_n_o    = !bus_active(state_q);
    assign ck_o      = ck_q;
    assign dq_oe_o   = (state_q == ST_CA) || (state_q == ST_WDATA);
    assign reset_n_o = reset_n_q;

endmodule

// ==== src/hyper_ctrl_top.sv ====
/*
 * HyperBus controller top: FSM, phase timer, TX shifter, RX capture,
 * pad and response packing
 */

`timescale 1ns/100ps

module hyper_ctrl_top (
    input  logic                      sys_clk,
    input  logic                      reset_i,
    input  logic                      req_i,
    output logic                      ack_o,
    input  hyper_pkg::host_req_t      host_req_i,
    output hyper_pkg::host_rsp_t      host_rsp_o,
    output hyper_pkg::hyper_pad_out_t pad_o,
    input  hyper_pkg::hyper_pad_in_t  pad_i
);
    import hyper_pkg::*;

    logic               timer_done;
    logic               timer_load;
    logic [TIMER_W-1:0] timer_count;
    logic               tx_load;
    logic               tx_shift;
    logic [BYTE_W-1:0]  tx_dq;
    logic               rx_clear;
    logic               rx_enable;
    logic               rx_full;
    logic [DATA_W-1:0]  rx_word;
    logic               err;
    logic               cs_n;
    logic               ck;
    logic               dq_oe;
    logic               reset_n;

    hyper_txn_fsm i_hyper_txn_fsm (
        .sys_clk       (sys_clk),
        .reset_i       (reset_i),
        .req_i         (req_i),
        .ack_o         (ack_o),
        .cmd_i         (host_req_i.cmd),
        .timer_done_i  (timer_done),
        .timer_load_o  (timer_load),
        .timer_count_o (timer_count),
        .tx_load_o     (tx_load),
        .tx_shift_o    (tx_shift),
        .rx_clear_o    (rx_clear),
        .rx_enable_o   (rx_enable),
        .rx_full_i     (rx_full),
        .err_o         (err),
        .cs_n_o        (cs_n),
        .ck_o          (ck),
        .dq_oe_o       (dq_oe),
        .reset_n_o     (reset_n)
    );

    hyper_phase_timer i_hyper_phase_timer (
        .sys_clk (sys_clk),
        .reset_i (reset_i),
        .load_i  (timer_load),
        .count_i (timer_count),
        .done_o  (timer_done)
    );

    hyper_tx_shifter i_hyper_tx_shifter (
        .sys_clk (sys_clk),
        .reset_i (reset_i),
        .load_i  (tx_load),
        .req_i   (host_req_i),
        .shift_i (tx_shift),
        .dq_o    (tx_dq)
    );

    hyper_rx_capture i_hyper_rx_capture (
        .sys_clk  (sys_clk),
        .reset_i  (reset_i),
        .clear_i  (rx_clear),
        .enable_i (rx_enable),
        .pad_i    (pad_i),
        .word_o   (rx_word),
        .full_o   (rx_full)
    );

    assign pad_o = '{cs_n: cs_n, ck: ck, reset_n: reset_n, dq: tx_dq, dq_oe: dq_oe};

    assign host_rsp_o = '{rdata: rx_word, err: err};

endmodule

// ==== dv/hyper_ram_model.sv ====
/*
 * Behavioral HyperRAM device: CA decode, fill-pattern memory,
 * RWDS-marked read data after a wait, silent mode
 */

`timescale 1ns/100ps

module hyper_ram_model (
    input  logic                      sys_clk,
    input  logic                      silent_i,
    input  logic [1:0]                wait_i,
    input  hyper_pkg::hyper_pad_out_t pad_i,
    output hyper_pkg::hyper_pad_in_t  pad_o
);
    import hyper_pkg::*;

    // First cycle after CA and latency, counted from cs_n low
    localparam int DATA_START = CA_BYTES + LATENCY_BYTES + 1;

    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
    logic [CA_W-1:0]   ca;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] word;
    int                idx = 0;
    int                rd_start;
    hyper_pad_in_t     drive = '0;

    assign pad_o = drive;

    always @(negedge sys_clk) begin
        drive = '0;
        if (pad_i.cs_n || !pad_i.reset_n) begin
            idx = 0;
        end else begin
            idx = idx + 1;
            if (idx <= CA_BYTES) begin
                ca = {ca[CA_W-BYTE_W-1:0], pad_i.dq};
                // Valid once the last CA byte is in
                addr = {ca[16 +: ADDR_W-3], ca[2:0]};
                rd_start = DATA_START + int'(wait_i);
                word = mem.exists(addr) ? mem[addr] : (addr[15:0] ^ 16'hA5C3);
            end else if (!ca[47]) begin
                // Write data, high byte first
                if (pad_i.dq_oe && (idx == DATA_START)) begin
                    word[15:8] = pad_i.dq;
                end else if (pad_i.dq_oe && (idx == DATA_START + 1)) begin
                    mem[addr] = {word[15:8], pad_i.dq};
                end
            end else if (!silent_i && !pad_i.dq_oe) begin
                if (idx == rd_start) begin
                    drive = '{dq: word[15:8], rwds: 1'b1};
                end else if (idx == rd_start + 1) begin
                    drive = '{dq: word[7:0], rwds: 1'b1};
                end
            end
        end
    end

endmodule

// ==== dv/hyper_ctrl_chk.sv ====
/*
 * Concurrent assertions on the controller handshake and pads
 */

`timescale 1ns/100ps

module hyper_ctrl_chk (
    input logic                      sys_clk,
    input logic                      reset_i,
    input logic                      req_i,
    input logic                      ack_i,
    input hyper_pkg::hyper_pad_out_t pad_i
);

    ack_needs_req: assert property (@(posedge sys_clk) disable iff (reset_i)
        $rose(ack_i) |-> $past(req_i))
        else $error("ack_o rose while req_i was low");

    no_drive_when_idle: assert property (@(posedge sys_clk) disable iff (reset_i)
        pad_i.cs_n |-> !pad_i.dq_oe)
        else $error("dq_oe high with cs_n high");

    ck_low_when_idle: assert property (@(posedge sys_clk) disable iff (reset_i)
        pad_i.cs_n |-> !pad_i.ck)
        else $error("ck high with cs_n high");

    no_start_during_ack: assert property (@(posedge sys_clk) disable iff (reset_i)
        $fell(pad_i.cs_n) |-> !ack_i && !$past(ack_i))
        else $error("cs_n fell while ack_o was high");

endmodule

// ==== dv/hyper_ctrl_tb.sv ====
/*
 * HyperBus controller testbench with clock, reset, LFSR stimulus,
 * reference model, response and pad checks
 */

`timescale 1ns/100ps

module hyper_ctrl_tb;
    import hyper_pkg::*;

    localparam int WRITE_ACK_CYCLE = 22;
    localparam int TXN_TIMEOUT     = 200;
    localparam int DROP_TIMEOUT    = 8;

    logic              sys_clk;
    logic              reset_i;
    logic              req;
    logic              ack;
    host_req_t         host_req;
    host_rsp_t         host_rsp;
    hyper_pad_out_t    pad_out;
    hyper_pad_in_t     pad_in;
    logic              silent;
    logic [1:0]        dev_wait;
    logic              ack_seen = 1'b0;
    logic [15:0]       lfsr = 16'd16515;
    int                mismatches = 0;
    int                failures = 0;
    host_rsp_t         exp_q [$];
    bit                data_q [$];
    logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];

    hyper_ctrl_top i_hyper_ctrl_top (
        .sys_clk    (sys_clk),
        .reset_i    (reset_i),
        .req_i      (req),
        .ack_o      (ack),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp),
        .pad_o      (pad_out),
        .pad_i      (pad_in)
    );

    hyper_ram_model i_hyper_ram_model (
        .sys_clk  (sys_clk),
        .silent_i (silent),
        .wait_i   (dev_wait),
        .pad_i    (pad_out),
        .pad_o    (pad_in)
    );

    bind hyper_ctrl_top hyper_ctrl_chk i_hyper_ctrl_chk (
        .sys_clk (sys_clk),
        .reset_i (reset_i),
        .req_i   (req_i),
        .ack_i   (ack_o),
        .pad_i   (pad_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = galois_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Shadow of the writes over the fill rule
    function automatic host_rsp_t expected_rsp(input host_req_t r);
        host_rsp_t rsp;
        rsp = '{rdata: r.addr[15:0] ^ 16'hA5C3, err: 1'b0};
        if (r.cmd == CMD_WRITE) begin
            shadow[r.addr] = r.wdata;
        end else if (shadow.exists(r.addr)) begin
            rsp.rdata = shadow[r.addr];
        end
        return rsp;
    endfunction

    // Read flag, memory space, linear burst, upper and lower address
    function automatic logic [CA_W-1:0] ca_word(input host_req_t r);
        return {r.cmd == CMD_READ, 2'b01, 8'h00, r.addr[ADDR_W-1:3], 13'h0000, r.addr[2:0]};
    endfunction

    // Expected pads in bus cycle n, where cycle 1 is the first with cs_n low
    function automatic hyper_pad_out_t bus_pads(input host_req_t r, input int n);
        hyper_pad_out_t  p;
        logic [TX_W-1:0] bytes;
        int              k;
        bytes = {ca_word(r), r.wdata};
        k = -1;
        p = '{cs_n: 1'b0, ck: n[0], reset_n: 1'b1, dq: '0, dq_oe: 1'b0};
        if (n <= CA_BYTES) begin
            k = n - 1;
        end else if ((r.cmd == CMD_WRITE) && (n > CA_BYTES + LATENCY_BYTES)
                     && (n <= CA_BYTES + LATENCY_BYTES + DATA_BYTES)) begin
            k = n - 1 - LATENCY_BYTES;
        end
        if (k >= 0) begin
            p.dq_oe = 1'b1;
            p.dq = bytes[TX_W - 1 - k * BYTE_W -: BYTE_W];
        end
        return p;
    endfunction

    task automatic check_rsp(input host_rsp_t got, input host_rsp_t exp, input bit with_data);
        if ((got.err !== exp.err) || (with_data && (got.rdata !== exp.rdata))) begin
            $display("mismatch at %0t ns: rsp rdata=%h err=%b, expected rdata=%h err=%b",
                     $time, got.rdata, got.err, exp.rdata, exp.err);
            mismatches++;
        end
    endtask

    task automatic check_pads(input hyper_pad_out_t got, input hyper_pad_out_t exp,
                              input bit with_dq);
        if ((got.cs_n !== exp.cs_n) || (got.ck !== exp.ck) || (got.reset_n !== exp.reset_n)
            || (got.dq_oe !== exp.dq_oe) || (with_dq && (got.dq !== exp.dq))) begin
            $display("mismatch at %0t ns: pads cs_n,ck,reset_n,dq,dq_oe = %b,%b,%b,%h,%b",
                     $time, got.cs_n, got.ck, got.reset_n, got.dq, got.dq_oe);
            mismatches++;
        end
    endtask

    task automatic check_ack(input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: ack_o=%b, expected %b", $time, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("mismatch at %0t ns: write ack at cycle %0d, expected %0d", $time, got, exp);
            mismatches++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if ((mismatches == 0) && (failures == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic run_txn(input host_req_t r, input logic exp_err, input int hold);
        host_rsp_t      exp;
        hyper_pad_out_t exp_pads;
        int             cycles;
        int             lat;
        exp = expected_rsp(r);
        exp.err = exp_err;
        exp_q.push_back(exp);
        data_q.push_back((r.cmd == CMD_READ) && !exp_err);
        host_req = r;
        req = 1'b1;
        cycles = 0;
        lat = 0;
        while (!ack && (cycles < TXN_TIMEOUT)) begin
            @(negedge sys_clk);
            cycles++;
            // Cycle 1 is the first with cs_n low
            if ((lat > 0) || !pad_out.cs_n) begin
                lat++;
            end
            if (!pad_out.cs_n) begin
                exp_pads = bus_pads(r, lat);
                check_pads(pad_out, exp_pads, exp_pads.dq_oe);
            end
        end
        if (!ack) begin
            $display("timeout at %0t ns: no ack for request to address %h", $time, r.addr);
            failures++;
            finish_run();
        end else begin
            if (r.cmd == CMD_WRITE) begin
                check_latency(lat, WRITE_ACK_CYCLE);
            end
            // Host holds req so ack stays up and the bus stays idle
            repeat (hold) begin
                @(negedge sys_clk);
                check_ack(ack, 1'b1);
                check_pads(pad_out, '{cs_n: 1, ck: 0, reset_n: 1, dq: 0, dq_oe: 0}, 1'b0);
            end
            req = 1'b0;
            cycles = 0;
            while (ack && (cycles < DROP_TIMEOUT)) begin
                @(negedge sys_clk);
                cycles++;
            end
            if (ack) begin
                $display("timeout at %0t ns: ack_o stayed high after req_i dropped", $time);
                failures++;
                finish_run();
            end
        end
    endtask

    // Compares each response on the cycle ack_o rises
    always @(negedge sys_clk) begin : compare
        host_rsp_t exp;
        bit        with_data;
        if (ack && !ack_seen) begin
            if (exp_q.size() == 0) begin
                $display("unexpected ack_o at %0t ns with no request outstanding", $time);
                failures++;
            end else begin
                exp = exp_q.pop_front();
                with_data = data_q.pop_front();
                check_rsp(host_rsp, exp, with_data);
            end
        end
        ack_seen = ack;
    end

    initial begin
        host_req_t         r;
        hyper_cmd_e        cmd;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        reset_i = 1'b1;
        req = 1'b0;
        host_req = '{cmd: CMD_READ, addr: '0, wdata: '0};
        silent = 1'b0;
        dev_wait = 2'd0;
        repeat (4) @(negedge sys_clk);
        check_pads(pad_out, '{cs_n: 1, ck: 0, reset_n: 0, dq: 0, dq_oe: 0}, 1'b0);
        check_ack(ack, 1'b0);
        @(negedge sys_clk);
        reset_i = 1'b0;
        @(negedge sys_clk);
        check_pads(pad_out, '{cs_n: 1, ck: 0, reset_n: 1, dq: 0, dq_oe: 0}, 1'b0);
        check_ack(ack, 1'b0);

        // Write and read back one address and read an unwritten one
        r = '{cmd: CMD_WRITE, addr: 24'h12_3456, wdata: 16'hBEEF};
        run_txn(r, 1'b0, 0);
        r.cmd = CMD_READ;
        run_txn(r, 1'b0, 0);
        r = '{cmd: CMD_READ, addr: 24'hFE_DCBA, wdata: '0};
        run_txn(r, 1'b0, 0);

        // Sixteen addresses spread over the whole range
        for (int i = 0; i < 60; i++) begin
            dev_wait = 2'(take_bits(2));
            cmd = take_bits(1) ? CMD_WRITE : CMD_READ;
            addr = ADDR_W'(take_bits(4) * 32'h0005_3A17);
            wdata = DATA_W'(take_bits(16));
            r = '{cmd: cmd, addr: addr, wdata: wdata};
            run_txn(r, 1'b0, 0);
        end

        // Silent device times out and the next read recovers
        silent = 1'b1;
        r = '{cmd: CMD_READ, addr: 24'h00_0042, wdata: '0};
        run_txn(r, 1'b1, 0);
        silent = 1'b0;
        run_txn(r, 1'b0, 0);

        // Host holds req after ack
        r = '{cmd: CMD_WRITE, addr: 24'h00_0042, wdata: 16'h1234};
        run_txn(r, 1'b0, 4);
        r.cmd = CMD_READ;
        run_txn(r, 1'b0, 3);

        if (exp_q.size() != 0) begin
            $display("%0d responses never arrived", exp_q.size());
            failures++;
        end
        finish_run();
    end

endmodule

// ==== build.f ====
src/hyper_pkg.sv
src/hyper_phase_timer.sv
src/hyper_tx_shifter.sv
src/hyper_rx_capture.sv
src/hyper_txn_fsm.sv
src/hyper_ctrl_top.sv
dv/hyper_ram_model.sv
dv/hyper_ctrl_chk.sv
dv/hyper_ctrl_tb.sv
